// ==== logic/isa_pkg.sv ====
package isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_CNT   = 16;
    localparam int REG_IDX_W = 4;
    localparam int CONST_W   = 19;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // any opcode not listed here halts the core
    typedef enum logic [4:0] {
        op_ld   = 5'b00000,
        op_ldi  = 5'b00001,
        op_st   = 5'b00010,
        op_halt = 5'b11011
    } opcode_e;

    // instruction word fields
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 27;
    localparam int RA_MSB     = 26;
    localparam int RA_LSB     = 23;
    localparam int RB_MSB     = 22;
    localparam int RB_LSB     = 19;
    localparam int CONST_MSB  = 18;
    localparam int CONST_LSB  = 0;

endpackage

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // one state per step of the instruction
    typedef enum logic [2:0] {
        s_fetch,
        s_decode,
        s_base,
        s_addr,
        s_mem,
        s_writeback,
        s_halt
    } ctrl_state_e;

    // where the memory address comes from
    typedef enum logic {
        addr_pc,
        addr_mar
    } addr_src_e;

    // what goes back into ra
    typedef enum logic {
        wb_mdr,
        wb_z
    } wb_src_e;

endpackage

// ==== logic/control_fsm.sv ====
`timescale 1ns/1ns

module control_fsm import isa_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  opcode_e   opcode,
    input  logic      mem_done,
    output logic      mem_req,
    output logic      mem_we,
    output addr_src_e addr_src,
    output logic      pc_inc,
    output logic      ir_load,
    output logic      y_load,
    output logic      z_load,
    output logic      mar_load,
    output logic      mdr_load,
    output logic      reg_we,
    output wb_src_e   wb_src,
    output logic      halted
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        req_sent;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= s_fetch;
            req_sent <= 1'b0;
        end else begin
            state <= state_next;
            // one request per memory step
            if (mem_done) begin
                req_sent <= 1'b0;
            end else if (mem_req) begin
                req_sent <= 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_fetch: begin
                if (mem_done) begin
                    state_next = s_decode;
                end
            end
            s_decode: begin
                case (opcode)
                    op_ld, op_ldi, op_st: state_next = s_base;
                    default:              state_next = s_halt;
                endcase
            end
            s_base: begin
                state_next = s_addr;
            end
            s_addr: begin
                // ldi needs no memory access
                state_next = (opcode == op_ldi) ? s_writeback : s_mem;
            end
            s_mem: begin
                if (mem_done) begin
                    state_next = (opcode == op_ld) ? s_writeback : s_fetch;
                end
            end
            s_writeback: begin
                state_next = s_fetch;
            end
            default: begin
                state_next = s_halt;
            end
        endcase
    end

    assign mem_req  = ((state == s_fetch) || (state == s_mem)) && !req_sent;
    assign mem_we   = (state == s_mem) && (opcode == op_st);
    assign addr_src = (state == s_mem) ? addr_mar : addr_pc;

    // pc moves on once the fetch has landed in IR
    assign pc_inc   = (state == s_decode);
    assign ir_load  = (state == s_fetch) && mem_done;
    assign y_load   = (state == s_base);
    assign z_load   = (state == s_addr);
    assign mar_load = (state == s_addr);
    assign mdr_load = (state == s_mem) && mem_done && (opcode == op_ld);
    assign reg_we   = (state == s_writeback);
    assign wb_src   = (opcode == op_ld) ? wb_mdr : wb_z;
    assign halted   = (state == s_halt);

    // a halted core stays off the bus
    a_no_req_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |-> !mem_req
    );

endmodule

// ==== logic/program_counter.sv ====
`timescale 1ns/1ns

module program_counter #(
    parameter int ADDR_W = 9
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pc_inc,
    output logic [ADDR_W-1:0] pc
);

    // word address that wraps at the top of memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ns

module register_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t ra_idx,
    input  reg_idx_t rb_idx,
    input  logic     reg_we,
    input  word_t    wr_data,
    output word_t    ra_data,
    output word_t    base_data
);

    word_t regs [REG_CNT];

    // writeback always targets ra
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            regs[ra_idx] <= wr_data;
        end
    end

    assign ra_data = regs[ra_idx];

    // r0 as base means no base
    assign base_data = (rb_idx == '0) ? '0 : regs[rb_idx];

    a_reg_we_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(reg_we)
    );

endmodule

// ==== logic/operand_path.sv ====
`timescale 1ns/1ns

module operand_path import isa_pkg::*, ctrl_pkg::*; #(
    parameter int ADDR_W = 9
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ir_load,
    input  logic              y_load,
    input  logic              z_load,
    input  logic              mar_load,
    input  logic              mdr_load,
    input  addr_src_e         addr_src,
    input  wb_src_e           wb_src,
    input  logic [ADDR_W-1:0] pc,
    input  word_t             mem_rdata,
    input  word_t             base_data,
    input  word_t             ra_data,
    output opcode_e           opcode,
    output reg_idx_t          ra_idx,
    output reg_idx_t          rb_idx,
    output logic [ADDR_W-1:0] mem_addr,
    output word_t             mem_wdata,
    output word_t             wr_data
);

    word_t             ir;
    word_t             y;
    word_t             z;
    word_t             mdr;
    logic [ADDR_W-1:0] mar;
    word_t             const_sext;
    word_t             ea_sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir  <= '0;
            mar <= '0;
        end else begin
            if (ir_load) begin
                ir <= mem_rdata;
            end
            if (mar_load) begin
                mar <= ea_sum[ADDR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (y_load) begin
            y <= base_data;
        end
        if (z_load) begin
            z <= ea_sum;
        end
        if (mdr_load) begin
            mdr <= mem_rdata;
        end
    end

    assign opcode = opcode_e'(ir[OPCODE_MSB:OPCODE_LSB]);
    assign ra_idx = ir[RA_MSB:RA_LSB];
    assign rb_idx = ir[RB_MSB:RB_LSB];

    // effective address adder
    assign const_sext = {{(WORD_W-CONST_W){ir[CONST_MSB]}}, ir[CONST_MSB:CONST_LSB]};
    assign ea_sum     = y + const_sext;

    assign mem_addr  = (addr_src == addr_mar) ? mar : pc;
    assign mem_wdata = ra_data;

    // ldi writes back the truncated effective address
    assign wr_data = (wb_src == wb_z) ? {{(WORD_W-ADDR_W){1'b0}}, z[ADDR_W-1:0]} : mdr;

endmodule

// ==== logic/apb_master.sv ====
`timescale 1ns/1ns

module apb_master import isa_pkg::*; #(
    parameter int ADDR_W = 9
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_req,
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_addr,
    input  word_t             mem_wdata,
    input  word_t             prdata,
    input  logic              pready,
    output logic              mem_done,
    output word_t             mem_rdata,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [ADDR_W-1:0] paddr,
    output word_t             pwdata
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_setup,
        ph_access
    } apb_phase_e;

    apb_phase_e phase;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= ph_idle;
            pwrite <= 1'b0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (mem_req) begin
                        phase  <= ph_setup;
                        pwrite <= mem_we;
                    end
                end
                ph_setup: begin
                    phase <= ph_access;
                end
                default: begin
                    // hold everything until the slave is ready
                    if (pready) begin
                        phase <= ph_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((phase == ph_idle) && mem_req) begin
            paddr  <= mem_addr;
            pwdata <= mem_wdata;
        end
    end

    assign psel      = (phase != ph_idle);
    assign penable   = (phase == ph_access);
    assign mem_done  = penable && pready;
    assign mem_rdata = prdata;

    a_penable_psel: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    );

    a_paddr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        penable && !pready |=> penable && $stable(paddr)
    );

endmodule

// ==== logic/mini_cpu_top.sv ====
`timescale 1ns/1ns

module mini_cpu_top import isa_pkg::*, ctrl_pkg::*; #(
    parameter int ADDR_W = 9
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              halted,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output logic [ADDR_W-1:0] paddr,
    output word_t             pwdata,
    input  word_t             prdata,
    input  logic              pready
);

    logic              mem_req;
    logic              mem_we;
    logic              mem_done;
    logic [ADDR_W-1:0] mem_addr;
    word_t             mem_wdata;
    word_t             mem_rdata;
    addr_src_e         addr_src;
    wb_src_e           wb_src;
    logic              pc_inc;
    logic              ir_load;
    logic              y_load;
    logic              z_load;
    logic              mar_load;
    logic              mdr_load;
    logic              reg_we;
    logic [ADDR_W-1:0] pc;
    opcode_e           opcode;
    reg_idx_t          ra_idx;
    reg_idx_t          rb_idx;
    word_t             ra_data;
    word_t             base_data;
    word_t             wr_data;

    control_fsm u_control_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .opcode   (opcode),
        .mem_done (mem_done),
        .mem_req  (mem_req),
        .mem_we   (mem_we),
        .addr_src (addr_src),
        .pc_inc   (pc_inc),
        .ir_load  (ir_load),
        .y_load   (y_load),
        .z_load   (z_load),
        .mar_load (mar_load),
        .mdr_load (mdr_load),
        .reg_we   (reg_we),
        .wb_src   (wb_src),
        .halted   (halted)
    );

    program_counter #(.ADDR_W(ADDR_W)) u_program_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .pc_inc (pc_inc),
        .pc     (pc)
    );

    register_file u_register_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .ra_idx    (ra_idx),
        .rb_idx    (rb_idx),
        .reg_we    (reg_we),
        .wr_data   (wr_data),
        .ra_data   (ra_data),
        .base_data (base_data)
    );

    operand_path #(.ADDR_W(ADDR_W)) u_operand_path (
        .clk       (clk),
        .rst_n     (rst_n),
        .ir_load   (ir_load),
        .y_load    (y_load),
        .z_load    (z_load),
        .mar_load  (mar_load),
        .mdr_load  (mdr_load),
        .addr_src  (addr_src),
        .wb_src    (wb_src),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .base_data (base_data),
        .ra_data   (ra_data),
        .opcode    (opcode),
        .ra_idx    (ra_idx),
        .rb_idx    (rb_idx),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .wr_data   (wr_data)
    );

    apb_master #(.ADDR_W(ADDR_W)) u_apb_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .prdata    (prdata),
        .pready    (pready),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata)
    );

endmodule

// ==== verif/mini_cpu_tb.sv ====
`timescale 1ns/1ns

module mini_cpu_tb import isa_pkg::*; ();

    localparam int ADDR_W    = 9;
    localparam int MEM_DEPTH = 1 << ADDR_W;
    localparam int REC_BASE  = 'h1e0;
    localparam int MAX_RECS  = 15;
    localparam int RUN_LIMIT = 4000;
    localparam int IDLE_WIN  = 32;

    logic              clk;
    logic              rst_n;
    logic              halted;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    word_t             pwdata;
    word_t             prdata;
    logic              pready;

    word_t             mem [MEM_DEPTH];
    word_t             rd_addr_q [$];
    word_t             wr_addr_q [$];
    word_t             wr_data_q [$];
    string             store_names [$];
    integer            seed;
    int                wait_left;
    logic              stalled;
    logic [ADDR_W-1:0] stall_addr;
    int                stall_cycles;
    int                proto_errors;
    int                test_errors;
    int                pass_count;
    int                fail_count;
    int                rec_count;
    int                halt_addr;
    logic              aborted;

    mini_cpu_top #(.ADDR_W(ADDR_W)) u_mini_cpu_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .halted  (halted),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic serve_access();
        if (pwrite) begin
            mem[paddr] = pwdata;
            wr_addr_q.push_back(word_t'(paddr));
            wr_data_q.push_back(pwdata);
        end else begin
            prdata = mem[paddr];
            rd_addr_q.push_back(word_t'(paddr));
        end
    endtask

    // apb memory model answering on the falling edge
    always @(negedge clk) begin
        word_t rnd;
        if (!rst_n) begin
            pready  = 1'b0;
            stalled = 1'b0;
        end else begin
            if (penable && !psel) begin
                proto_errors++;
                $display("penable was high without psel at %0t", $time);
            end
            if (stalled && (penable !== 1'b1 || paddr !== stall_addr)) begin
                proto_errors++;
                $display("access phase changed while stalled at %0t", $time);
            end
            if (psel && !penable) begin
                // setup phase picks the wait states for this access
                rnd       = $random(seed);
                wait_left = rnd[1:0];
                pready    = 1'b0;
            end else if (psel && penable) begin
                if (wait_left > 0) begin
                    wait_left--;
                    pready = 1'b0;
                    stall_cycles++;
                end else begin
                    pready = 1'b1;
                    serve_access();
                end
            end else begin
                pready = 1'b0;
            end
            stalled    = psel && penable && !pready;
            stall_addr = paddr;
        end
    end

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%-14s pass", name);
        end else begin
            fail_count++;
            $display("%-14s fail, %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic record_abort(input string reason);
        $display("%s", reason);
        aborted = 1'b1;
    endtask

    task automatic run_tests();
        int    cycles;
        int    fetch_next;
        int    bus_busy;
        string name;
        rec_count = mem[REC_BASE];
        halt_addr = mem[REC_BASE + 1];
        if (rec_count < 0 || rec_count > MAX_RECS || halt_addr < 0 || halt_addr >= REC_BASE) begin
            record_abort("test data file did not load or has a bad header");
            return;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        if (psel !== 1'b0 || penable !== 1'b0) begin
            test_errors++;
            $display("Mismatch reset: expected psel 0 penable 0 actual psel %b penable %b",
                     psel, penable);
        end
        if (halted !== 1'b0) begin
            test_errors++;
            $display("Mismatch reset: expected halted 0 actual %b", halted);
        end
        cycles = 0;
        while (psel !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (psel !== 1'b1) begin
            record_abort("no APB transfer started after reset");
            return;
        end
        if (pwrite !== 1'b0) begin
            test_errors++;
            $display("Mismatch reset: expected pwrite 0 actual %b", pwrite);
        end
        if (paddr !== '0) begin
            test_errors++;
            $display("Mismatch reset: expected paddr %h actual %h", 9'h000, paddr);
        end
        end_test("reset");

        cycles = 0;
        while (halted !== 1'b1 && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            record_abort("core did not halt within the cycle limit");
            return;
        end

        // bus must stay quiet once halted
        bus_busy = 0;
        cycles   = 0;
        while (cycles < IDLE_WIN) begin
            @(negedge clk);
            if (psel !== 1'b0) begin
                bus_busy++;
            end
            if (halted !== 1'b1) begin
                test_errors++;
                $display("Mismatch halt: expected halted 1 actual %b", halted);
            end
            cycles++;
        end
        if (bus_busy != 0) begin
            test_errors++;
            $display("Mismatch halt: expected 0 active APB cycles actual %0d", bus_busy);
        end
        end_test("halt");

        // data reads sit above the program, so low reads are fetches
        fetch_next = 0;
        foreach (rd_addr_q[i]) begin
            if (rd_addr_q[i] <= halt_addr) begin
                if (rd_addr_q[i] != fetch_next) begin
                    test_errors++;
                    $display("Mismatch fetch_order: expected %h actual %h",
                             fetch_next, rd_addr_q[i]);
                end
                fetch_next = rd_addr_q[i] + 1;
            end
        end
        if (fetch_next != halt_addr + 1) begin
            test_errors++;
            $display("Mismatch fetch_order: expected last fetch %h actual %h",
                     halt_addr, fetch_next - 1);
        end
        end_test("fetch_order");

        for (int i = 0; i < rec_count; i++) begin
            name = (i < store_names.size()) ? store_names[i] : $sformatf("store_%0d", i);
            if (i >= wr_addr_q.size()) begin
                test_errors++;
                $display("%s: the expected store never happened", name);
            end else begin
                if (wr_addr_q[i] !== mem[REC_BASE + 2 + 2 * i]) begin
                    test_errors++;
                    $display("Mismatch %s address: expected %h actual %h",
                             name, mem[REC_BASE + 2 + 2 * i], wr_addr_q[i]);
                end
                if (wr_data_q[i] !== mem[REC_BASE + 3 + 2 * i]) begin
                    test_errors++;
                    $display("Mismatch %s data: expected %h actual %h",
                             name, mem[REC_BASE + 3 + 2 * i], wr_data_q[i]);
                end
            end
            end_test(name);
        end
        if (wr_addr_q.size() != rec_count) begin
            test_errors++;
            $display("Mismatch store_count: expected %0d actual %0d",
                     rec_count, wr_addr_q.size());
        end
        end_test("store_count");

        if (proto_errors != 0) begin
            test_errors += proto_errors;
        end
        if (stall_cycles == 0) begin
            test_errors++;
            $display("no wait states were inserted during the run");
        end
        end_test("apb_protocol");
    endtask

    initial begin
        seed         = 32'ha0eb8081;
        rst_n        = 1'b0;
        pready       = 1'b0;
        prdata       = '0;
        wait_left    = 0;
        stalled      = 1'b0;
        stall_addr   = '0;
        stall_cycles = 0;
        proto_errors = 0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        aborted      = 1'b0;
        store_names  = '{"ld_direct", "ldi_direct", "ld_indexed", "ldi_indexed",
                         "ldi_negative", "st_indexed", "ldi_truncate", "st_negative",
                         "base_r0", "st_r0"};

        // every address bit shows up in the fill word
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = 32'h5a5a0000 | i;
        end
        $readmemh("verif/mini_cpu_testdata.hex", mem);

        run_tests();

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (!aborted && fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/control_fsm.sv
logic/program_counter.sv
logic/register_file.sv
logic/operand_path.sv
logic/apb_master.sv
logic/mini_cpu_top.sv
verif/mini_cpu_tb.sv

// ==== verif/mini_cpu_testdata.hex ====
// program at @000, data words at @040 and @04a, expected stores from @1e0
// @1e0 holds store count and halt address, then one store per line: address data
@000
00800040 // ld  r1, 0x40
10800080 // st  r1, 0x80
09000048 // ldi r2, 0x48
11000081 // st  r2, 0x81
01900002 // ld  r3, 2(r2)
11800082 // st  r3, 0x82
0a100005 // ldi r4, 5(r2)
12000083 // st  r4, 0x83
0a97fffd // ldi r5, -3(r2)
12800084 // st  r5, 0x84
10900040 // st  r1, 0x40(r2)
0b07ffff // ldi r6, -1
13000085 // st  r6, 0x85
11a7fff8 // st  r3, -8(r4)
08000010 // ldi r0, 0x10
0b800020 // ldi r7, 0x20(r0)
13800086 // st  r7, 0x86
10000087 // st  r0, 0x87
d8000000 // halt
@040 cafe1234
@04a 8765abcd
@1e0
0000000a 00000012
00000080 cafe1234
00000081 00000048
00000082 8765abcd
00000083 0000004d
00000084 00000045
00000088 cafe1234
00000085 000001ff
00000045 8765abcd
00000086 00000020
00000087 00000010
